//--- src/reflet_bus_pkg.sv
//----------------------------------------------------------------------
// Bus word and address types shared by the peripheral block, with the
// address map and the register offsets of the GPIO and timer units.
// Modules import it inside their body and use scoped names in ports.
//----------------------------------------------------------------------
package reflet_bus_pkg;

    typedef logic [15:0] word_t;    // CPU data word
    typedef logic [15:0] addr_t;    // CPU bus address
    typedef logic [1:0]  offset_t;  // Register inside one unit

    // Every unit owns a window of four registers
    localparam addr_t periph_base  = 16'hFF00;  // Hardware info at base+0..3
    localparam addr_t gpio_base    = periph_base + 16'd4;
    localparam addr_t timer_base   = periph_base + 16'd8;  // Timer i at +4i
    localparam int    timer_stride = 4;
    localparam int    max_timers   = 4;

    // GPIO registers
    localparam offset_t gpio_out_off = 2'd0;
    localparam offset_t gpio_in_off  = 2'd1;  // Read only

    // Timer registers
    localparam offset_t timer_reload_off = 2'd0;  // Write only, reads 0
    localparam offset_t timer_ctrl_off   = 2'd1;
    localparam offset_t timer_count_off  = 2'd2;  // Read only
    localparam offset_t timer_status_off = 2'd3;  // Any write clears the flag

    localparam int timer_enable_bit = 0;  // In control
    localparam int timer_wrap_bit   = 0;  // In status

endpackage

//--- src/reflet_info_pkg.sv
//----------------------------------------------------------------------
// Encodings of the hardware-information registers: the word-size code
// and the bit positions of the fields in the feature register.
//----------------------------------------------------------------------
package reflet_info_pkg;

    typedef logic [2:0] wordsize_code_t;

    localparam reflet_bus_pkg::offset_t info_clk_lsb_off = 2'd0;  // MHz bits 7:0
    localparam reflet_bus_pkg::offset_t info_clk_msb_off = 2'd1;  // MHz bits 15:8
    localparam reflet_bus_pkg::offset_t info_feature_off = 2'd2;

    localparam int info_word_lsb  = 0;
    localparam int info_word_msb  = 2;
    localparam int info_gpio_bit  = 3;
    localparam int info_timer_lsb = 4;
    localparam int info_timer_msb = 6;

    function automatic wordsize_code_t wordsize_code(input int wordsize);
        case (wordsize)
            8:       return 3'd1;
            16:      return 3'd2;
            32:      return 3'd3;
            64:      return 3'd4;
            128:     return 3'd5;
            default: return 3'd0;  // Unusual width
        endcase
    endfunction

endpackage

//--- src/reflet_periph_decoder.sv
//----------------------------------------------------------------------
// Address decoder of the peripheral block. Raises the select of the
// unit whose four-register window holds the bus address and passes the
// low address bits on as the register offset.
//----------------------------------------------------------------------
`timescale 1ns/10ps

module reflet_periph_decoder #(
    parameter int timer_count = 2
) (
    input  reflet_bus_pkg::addr_t   addr,
    output logic                    info_sel,
    output logic                    gpio_sel,
    output logic [timer_count-1:0]  timer_sel,
    output reflet_bus_pkg::offset_t offset
);
    import reflet_bus_pkg::*;

    localparam int map_end = int'(timer_base) + timer_stride * timer_count;  // First unmapped

    addr_t window;  // Address with the offset bits cleared

    assign window = {addr[15:2], 2'b00};
    assign offset = addr[1:0];

    assign info_sel = (window == periph_base);
    assign gpio_sel = (window == gpio_base);

    always_comb begin
        for (int i = 0; i < timer_count; i++) begin
            timer_sel[i] = (window == addr_t'(timer_base + timer_stride * i));
        end
    end

    // At most one unit answers, and one does for every address in the map
    always_comb begin
        assert ($onehot0({info_sel, gpio_sel, timer_sel}) &&
                ((addr >= periph_base && addr < map_end) ==
                 (|{info_sel, gpio_sel, timer_sel})))
            else $error("decoder selects %b wrong for address %h",
                        {info_sel, gpio_sel, timer_sel}, addr);
    end

endmodule

//--- src/reflet_hardware_info.sv
//----------------------------------------------------------------------
// Read-only registers that tell software how the block was built:
// clock frequency in MHz, word-size code, GPIO presence and the number
// of timers. Takes the same parameters as the peripheral top level.
//----------------------------------------------------------------------
`timescale 1ns/10ps

module reflet_hardware_info #(
    parameter int clk_freq    = 50_000_000,
    parameter int timer_count = 2,
    parameter int enable_gpio = 1
) (
    input  logic                    info_sel,
    input  reflet_bus_pkg::offset_t offset,
    output reflet_bus_pkg::word_t   read_data
);
    import reflet_bus_pkg::*;
    import reflet_info_pkg::*;

    localparam int             clk_mhz   = clk_freq / 1_000_000;
    localparam wordsize_code_t word_code = wordsize_code($bits(word_t));

    logic [7:0] clk_lsb;
    logic [7:0] clk_msb;
    logic [7:0] features;  // Word size, GPIO flag, timer count

    assign clk_lsb = 8'(clk_mhz);
    assign clk_msb = 8'(clk_mhz >> 8);

    always_comb begin
        features = '0;
        features[info_word_msb:info_word_lsb]   = word_code;
        features[info_gpio_bit]                 = (enable_gpio != 0);
        features[info_timer_msb:info_timer_lsb] = 3'(timer_count);
    end

    always_comb begin
        read_data = '0;
        if (info_sel) begin
            case (offset)
                info_clk_lsb_off: read_data[7:0] = clk_lsb;
                info_clk_msb_off: read_data[7:0] = clk_msb;
                info_feature_off: read_data[7:0] = features;
                default:          read_data = '0;  // Offset 3 reserved
            endcase
        end
    end

endmodule

//--- src/reflet_gpio.sv
//----------------------------------------------------------------------
// GPIO unit. Offset 0 is the output register, offset 1 shows gpio_in
// after a two-flop synchronizer. Built out, it reads zero and ignores
// writes.
//----------------------------------------------------------------------
`timescale 1ns/10ps

module reflet_gpio #(
    parameter int enable_gpio = 1
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    gpio_sel,
    input  reflet_bus_pkg::offset_t offset,
    input  logic                    write_en,
    input  reflet_bus_pkg::word_t   data_in,
    input  reflet_bus_pkg::word_t   gpio_in,
    output reflet_bus_pkg::word_t   read_data,
    output reflet_bus_pkg::word_t   gpio_out
);
    import reflet_bus_pkg::*;

    localparam bit present = (enable_gpio != 0);

    word_t out_reg;
    word_t sync_meta;  // First stage, may be metastable
    word_t sync_in;    // Safe for the bus

    assign gpio_out = out_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_reg   <= '0;
            sync_meta <= '0;
            sync_in   <= '0;
        end else begin
            if (present && gpio_sel && write_en && offset == gpio_out_off) begin
                out_reg <= data_in;
            end
            sync_meta <= present ? gpio_in : '0;
            sync_in   <= sync_meta;
        end
    end

    always_comb begin
        read_data = '0;
        if (present && gpio_sel) begin
            case (offset)
                gpio_out_off: read_data = out_reg;
                gpio_in_off:  read_data = sync_in;
                default:      read_data = '0;
            endcase
        end
    end

endmodule

//--- src/reflet_timer.sv
//----------------------------------------------------------------------
// One reloadable down-counter. Software writes reload, sets the enable
// bit in control, and polls count or the wrap flag in status. On zero
// the count reloads and the flag is set until software writes status.
//----------------------------------------------------------------------
`timescale 1ns/10ps

module reflet_timer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    timer_sel,
    input  reflet_bus_pkg::offset_t offset,
    input  logic                    write_en,
    input  reflet_bus_pkg::word_t   data_in,
    output reflet_bus_pkg::word_t   read_data
);
    import reflet_bus_pkg::*;

    word_t reload;
    word_t count;
    logic  enable;
    logic  wrap;
    logic  wr_reload;
    logic  wr_ctrl;
    logic  wr_status;

    assign wr_reload = timer_sel && write_en && offset == timer_reload_off;
    assign wr_ctrl   = timer_sel && write_en && offset == timer_ctrl_off;
    assign wr_status = timer_sel && write_en && offset == timer_status_off;

    always_ff @(posedge clk) begin
        if (rst) begin
            reload <= '0;
            count  <= '0;
            enable <= 1'b0;
            wrap   <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                enable <= data_in[timer_enable_bit];
            end
            if (wr_status) begin
                wrap <= 1'b0;
            end
            if (wr_reload) begin
                reload <= data_in;
                count  <= data_in;  // Restart from the new value
            end else if (enable) begin
                if (count == '0) begin
                    count <= reload;
                    wrap  <= 1'b1;  // Beats a clear in the same cycle
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    always_comb begin
        read_data = '0;
        if (timer_sel) begin
            case (offset)
                timer_ctrl_off:   read_data[timer_enable_bit] = enable;
                timer_count_off:  read_data = count;
                timer_status_off: read_data[timer_wrap_bit] = wrap;
                default:          read_data = '0;  // Reload is write only
            endcase
        end
    end

    // Count is only ever loaded from reload, so it cannot climb above it
    assert property (@(posedge clk) disable iff (rst) enable |-> count <= reload)
        else $error("timer count %0d above reload %0d", count, reload);

endmodule

//--- src/reflet_periph_read_merge.sv
//----------------------------------------------------------------------
// Read merge. ORs the read data of all units and registers it on
// data_out in the cycle of read_en, where it stays until the next read.
//----------------------------------------------------------------------
`timescale 1ns/10ps

module reflet_periph_read_merge #(
    parameter int timer_count = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  read_en,
    input  reflet_bus_pkg::word_t info_data,
    input  reflet_bus_pkg::word_t gpio_data,
    input  reflet_bus_pkg::word_t timer_data [timer_count],
    output reflet_bus_pkg::word_t data_out
);
    import reflet_bus_pkg::*;

    word_t                  merged;
    logic [timer_count+1:0] busy;  // Units driving non-zero data

    always_comb begin
        merged  = info_data | gpio_data;
        busy[0] = |info_data;
        busy[1] = |gpio_data;
        for (int i = 0; i < timer_count; i++) begin
            merged      = merged | timer_data[i];
            busy[i + 2] = |timer_data[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            data_out <= '0;
        end else if (read_en) begin
            data_out <= merged;
        end
    end

    // Units gate their data with their select, so only one may answer
    assert property (@(posedge clk) disable iff (rst) read_en |-> $onehot0(busy))
        else $error("several units drove read data at once: %b", busy);

endmodule

//--- src/reflet_periph.sv
//----------------------------------------------------------------------
// Peripheral block top level for the soft CPU bus. Set clk_freq,
// timer_count and enable_gpio here; they reach every unit from here.
// Writes land on the write_en edge, reads answer one cycle after read_en.
//----------------------------------------------------------------------
`timescale 1ns/10ps

module reflet_periph #(
    parameter int clk_freq    = 50_000_000,
    parameter int timer_count = 2,
    parameter int enable_gpio = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  reflet_bus_pkg::addr_t addr,
    input  reflet_bus_pkg::word_t data_in,
    input  logic                  write_en,
    input  logic                  read_en,
    input  reflet_bus_pkg::word_t gpio_in,
    output reflet_bus_pkg::word_t data_out,
    output reflet_bus_pkg::word_t gpio_out
);
    import reflet_bus_pkg::*;

    // Keep the timers inside their part of the address map
    localparam int timers = (timer_count < 1) ? 1 :
                            (timer_count > max_timers) ? max_timers : timer_count;

    logic              info_sel;
    logic              gpio_sel;
    logic [timers-1:0] timer_sel;
    offset_t           offset;
    word_t             info_data;
    word_t             gpio_data;
    word_t             timer_data [timers];

    reflet_periph_decoder #(.timer_count(timers)) u_decoder (
        .addr      (addr),
        .info_sel  (info_sel),
        .gpio_sel  (gpio_sel),
        .timer_sel (timer_sel),
        .offset    (offset)
    );

    reflet_hardware_info #(
        .clk_freq    (clk_freq),
        .timer_count (timers),
        .enable_gpio (enable_gpio)
    ) u_info (
        .info_sel  (info_sel),
        .offset    (offset),
        .read_data (info_data)
    );

    reflet_gpio #(.enable_gpio(enable_gpio)) u_gpio (
        .clk       (clk),
        .rst       (rst),
        .gpio_sel  (gpio_sel),
        .offset    (offset),
        .write_en  (write_en),
        .data_in   (data_in),
        .gpio_in   (gpio_in),
        .read_data (gpio_data),
        .gpio_out  (gpio_out)
    );

    for (genvar i = 0; i < timers; i++) begin : g_timer
        reflet_timer u_timer (
            .clk       (clk),
            .rst       (rst),
            .timer_sel (timer_sel[i]),
            .offset    (offset),
            .write_en  (write_en),
            .data_in   (data_in),
            .read_data (timer_data[i])
        );
    end

    reflet_periph_read_merge #(.timer_count(timers)) u_merge (
        .clk        (clk),
        .rst        (rst),
        .read_en    (read_en),
        .info_data  (info_data),
        .gpio_data  (gpio_data),
        .timer_data (timer_data),
        .data_out   (data_out)
    );

endmodule

//--- testbench/reflet_periph_model.svh
//----------------------------------------------------------------------
// Reference model of the peripheral register map for the testbench.
// Included inside the testbench module. advance_model is called once
// per clock with the bus inputs that the DUT samples on that edge.
//----------------------------------------------------------------------
`ifndef REFLET_PERIPH_MODEL_SVH
`define REFLET_PERIPH_MODEL_SVH

word_t ref_data_out;
word_t ref_gpio_out;
word_t ref_sync [2];  // gpio_in one and two edges back
word_t ref_reload [timers];
word_t ref_count [timers];
logic  ref_enable [timers];
logic  ref_wrap [timers];

function automatic void reset_model();
    ref_data_out = '0;
    ref_gpio_out = '0;
    ref_sync[0]  = '0;
    ref_sync[1]  = '0;
    for (int i = 0; i < timers; i++) begin
        ref_reload[i] = '0;
        ref_count[i]  = '0;
        ref_enable[i] = 1'b0;
        ref_wrap[i]   = 1'b0;
    end
endfunction

// Hardware information as the register layout defines it
function automatic word_t info_field(offset_t off);
    word_t mhz;
    logic  gpio_flag;
    mhz       = word_t'(clk_freq / 1_000_000);
    gpio_flag = (enable_gpio != 0);
    case (off)
        2'd0:    return {8'h00, mhz[7:0]};
        2'd1:    return {8'h00, mhz[15:8]};
        2'd2:    return {9'd0, 3'(timers), gpio_flag, 3'd2};  // Code 2 means 16-bit words
        default: return '0;
    endcase
endfunction

// Timer whose window holds the address, or -1
function automatic int timer_index(addr_t a);
    addr_t win;
    for (int i = 0; i < timers; i++) begin
        win = addr_t'(timer_base + 4 * i);
        if (a[15:2] == win[15:2]) begin
            return i;
        end
    end
    return -1;
endfunction

function automatic word_t expected_read(addr_t a);
    int t;
    t = timer_index(a);
    if (a[15:2] == periph_base[15:2]) begin
        return info_field(a[1:0]);
    end
    if (a[15:2] == gpio_base[15:2]) begin
        case (a[1:0])
            gpio_out_off: return ref_gpio_out;
            gpio_in_off:  return ref_sync[1];
            default:      return '0;
        endcase
    end
    if (t >= 0) begin
        case (a[1:0])
            timer_ctrl_off:   return {15'd0, ref_enable[t]};
            timer_count_off:  return ref_count[t];
            timer_status_off: return {15'd0, ref_wrap[t]};
            default:          return '0;  // Reload reads 0
        endcase
    end
    return '0;
endfunction

function automatic void advance_model(addr_t a, word_t d, logic we, logic re, word_t gin);
    int   t;
    logic hit;
    if (re) begin
        ref_data_out = expected_read(a);  // State before the edge
    end
    ref_sync[1] = ref_sync[0];
    ref_sync[0] = gin;
    if (we && a[15:2] == gpio_base[15:2] && a[1:0] == gpio_out_off) begin
        ref_gpio_out = d;
    end
    t = timer_index(a);
    for (int i = 0; i < timers; i++) begin
        hit = we && (t == i);
        if (hit && a[1:0] == timer_status_off) begin
            ref_wrap[i] = 1'b0;
        end
        if (hit && a[1:0] == timer_reload_off) begin
            ref_reload[i] = d;
            ref_count[i]  = d;
        end else if (ref_enable[i]) begin
            if (ref_count[i] == '0) begin
                ref_count[i] = ref_reload[i];
                ref_wrap[i]  = 1'b1;  // Wins over a clear on the same edge
            end else begin
                ref_count[i] = ref_count[i] - 16'd1;
            end
        end
        if (hit && a[1:0] == timer_ctrl_off) begin
            ref_enable[i] = d[0];  // Takes effect from the next edge
        end
    end
endfunction

`endif

//--- testbench/reflet_periph_tb.sv
//----------------------------------------------------------------------
// Testbench of the peripheral block. Runs directed phases and then
// random bus traffic from a fixed seed, and compares data_out and
// gpio_out with the included register model on every falling edge.
//----------------------------------------------------------------------
`timescale 1ns/10ps

module reflet_periph_tb;
    import reflet_bus_pkg::*;

    localparam int clk_freq        = 50_000_000;
    localparam int timers          = 2;
    localparam int enable_gpio     = 1;
    localparam int clk_period      = 4;     // ns
    localparam int reset_cycles    = 10;
    localparam int directed_cycles = 400;   // Bound on the directed phases
    localparam int random_cycles   = 2000;
    localparam int test_cycles     = reset_cycles + directed_cycles + random_cycles;
    localparam int map_size        = 8 + 4 * timers;  // Registers from periph_base

    logic  clk = 1'b0;
    logic  rst;
    addr_t addr;
    word_t data_in;
    logic  write_en;
    logic  read_en;
    word_t gpio_in;
    word_t data_out;
    word_t gpio_out;

    word_t pin_value;  // Next gpio_in level
    string test_name;
    int    errors;
    int    checks;

    `include "reflet_periph_model.svh"

    reflet_periph #(
        .clk_freq    (clk_freq),
        .timer_count (timers),
        .enable_gpio (enable_gpio)
    ) UUT (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .data_in  (data_in),
        .write_en (write_en),
        .read_en  (read_en),
        .gpio_in  (gpio_in),
        .data_out (data_out),
        .gpio_out (gpio_out)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic compare_outputs();
        checks++;
        if (data_out !== ref_data_out) begin
            errors++;
            $display("CHECK FAILED %s data_out expected %h actual %h",
                     test_name, ref_data_out, data_out);
        end
        if (gpio_out !== ref_gpio_out) begin
            errors++;
            $display("CHECK FAILED %s gpio_out expected %h actual %h",
                     test_name, ref_gpio_out, gpio_out);
        end
    endtask

    // One bus cycle; the outputs of the previous edge are checked midway
    task automatic bus_cycle(input addr_t a, input word_t d, input logic we, input logic re);
        @(posedge clk);
        addr     <= a;
        data_in  <= d;
        write_en <= we;
        read_en  <= re;
        gpio_in  <= pin_value;
        @(negedge clk);
        compare_outputs();
        advance_model(a, d, we, re, gpio_in);
    endtask

    task automatic write_reg(input addr_t a, input word_t d);
        bus_cycle(a, d, 1'b1, 1'b0);
    endtask

    task automatic read_reg(input addr_t a);
        bus_cycle(a, '0, 1'b0, 1'b1);
    endtask

    task automatic idle(input int n);
        repeat (n) bus_cycle('0, '0, 1'b0, 1'b0);
    endtask

    // Read and hold data_out for a check against a fixed value
    task automatic check_read(input addr_t a, input word_t expected);
        read_reg(a);
        idle(1);
        if (data_out !== expected) begin
            errors++;
            $display("CHECK FAILED %s data_out expected %h actual %h",
                     test_name, expected, data_out);
        end
    endtask

    // Reads every GPIO and timer register
    task automatic sweep_map();
        for (int i = 4; i < map_size; i++) begin
            read_reg(addr_t'(periph_base + i));
        end
    endtask

    function automatic addr_t timer_addr(input int i, input offset_t off);
        return addr_t'(timer_base + 4 * i + off);
    endfunction

    function automatic addr_t unmapped_addr();
        if ($urandom_range(1) == 0) begin
            return addr_t'($urandom_range(16'hFEFF));
        end
        return addr_t'(periph_base + map_size + $urandom_range(200));
    endfunction

    function automatic addr_t random_addr();
        if ($urandom_range(9) < 8) begin
            return addr_t'(periph_base + $urandom_range(map_size - 1));
        end
        return unmapped_addr();
    endfunction

    initial begin
        word_t d;
        void'($urandom(32'hb0b3_9966));
        rst       = 1'b1;
        addr      = '0;
        data_in   = '0;
        write_en  = 1'b0;
        read_en   = 1'b0;
        gpio_in   = '0;
        pin_value = '0;
        errors    = 0;
        checks    = 0;
        test_name = "reset";
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        reset_model();
        advance_model('0, '0, 1'b0, 1'b0, '0);  // Edge that first sees rst low
        sweep_map();

        test_name = "info";
        for (int i = 0; i < 4; i++) begin
            check_read(addr_t'(periph_base + i), info_field(offset_t'(i)));
        end

        test_name = "gpio";
        d = word_t'($urandom);
        write_reg(gpio_base, d);
        check_read(gpio_base, d);
        pin_value = word_t'($urandom);
        idle(1);
        read_reg(addr_t'(gpio_base + gpio_in_off));  // Still the old level
        check_read(addr_t'(gpio_base + gpio_in_off), pin_value);

        test_name = "timer";
        for (int i = 0; i < timers; i++) begin
            write_reg(timer_addr(i, timer_reload_off), word_t'(20 + 7 * i));
        end
        for (int i = 0; i < timers; i++) begin
            write_reg(timer_addr(i, timer_ctrl_off), 16'd1);
        end
        repeat (8) begin
            for (int i = 0; i < timers; i++) begin
                read_reg(timer_addr(i, timer_count_off));
            end
        end

        test_name = "wrap";
        write_reg(timer_addr(0, timer_reload_off), 16'd3);
        idle(6);
        write_reg(timer_addr(0, timer_ctrl_off), 16'd0);  // Freeze it
        check_read(timer_addr(0, timer_status_off), 16'h0001);
        write_reg(timer_addr(0, timer_status_off), 16'hFFFF);
        check_read(timer_addr(0, timer_status_off), 16'h0000);

        test_name = "unmapped";
        repeat (20) begin
            write_reg(unmapped_addr(), word_t'($urandom));
            check_read(unmapped_addr(), 16'h0000);
        end
        sweep_map();

        test_name = "random";
        for (int n = 0; n < random_cycles; n++) begin
            if ($urandom_range(3) == 0) begin
                pin_value = word_t'($urandom);
            end
            d = ($urandom_range(1) == 0) ? word_t'($urandom_range(40)) : word_t'($urandom);
            bus_cycle(random_addr(), d, $urandom_range(3) == 0, $urandom_range(1) == 1);
        end
        idle(2);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(test_cycles * clk_period * 2);
        $display("Watchdog expired after %0d ns, the run did not finish",
                 test_cycles * clk_period * 2);
        $display("test failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+testbench
src/reflet_bus_pkg.sv
src/reflet_info_pkg.sv
src/reflet_periph_decoder.sv
src/reflet_hardware_info.sv
src/reflet_gpio.sv
src/reflet_timer.sv
src/reflet_periph_read_merge.sv
src/reflet_periph.sv
testbench/reflet_periph_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the peripheral block testbench with Verilator, runs it and
# decides pass or fail from the simulation output.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module reflet_periph_tb -f sim.f -o reflet_periph_sim

sim_output="$(./obj_dir/reflet_periph_sim)"
echo "$sim_output"

if grep -qx "test passed" <<< "$sim_output"; then
    exit 0
fi
exit 1
